// File: common/isa_pkg.sv
package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	////////////////////
	// field positions
	////////////////////
	localparam int OP_LSB = 26;
	localparam int RS_LSB = 21;
	localparam int RT_LSB = 16;
	localparam int RD_LSB = 11;
	localparam int SA_LSB = 6;
	localparam int SA_W = 5;
	localparam int IMM_W = 16;
	localparam int JIDX_W = 26;
	// zero padding between rd and sel in mfc0/mtc0
	localparam int COP0_PAD_LSB = 3;
	localparam int COP0_PAD_W = 8;

	////////////////////
	// encodings
	////////////////////
	localparam opcode_t OPCODE_SPECIAL = 6'b000000;
	localparam opcode_t OPCODE_J = 6'b000010;
	localparam opcode_t OPCODE_JAL = 6'b000011;
	localparam opcode_t OPCODE_BEQ = 6'b000100;
	localparam opcode_t OPCODE_BNE = 6'b000101;
	localparam opcode_t OPCODE_ADDIU = 6'b001001;
	localparam opcode_t OPCODE_SLTI = 6'b001010;
	localparam opcode_t OPCODE_ANDI = 6'b001100;
	localparam opcode_t OPCODE_ORI = 6'b001101;
	localparam opcode_t OPCODE_XORI = 6'b001110;
	localparam opcode_t OPCODE_LUI = 6'b001111;
	localparam opcode_t OPCODE_COP0 = 6'b010000;
	localparam opcode_t OPCODE_LW = 6'b100011;
	localparam opcode_t OPCODE_SW = 6'b101011;

	// special group, selected by funct
	localparam funct_t FUNCT_SLL = 6'b000000;
	localparam funct_t FUNCT_SRL = 6'b000010;
	localparam funct_t FUNCT_SRA = 6'b000011;
	localparam funct_t FUNCT_JR = 6'b001000;
	localparam funct_t FUNCT_ADDU = 6'b100001;
	localparam funct_t FUNCT_SUBU = 6'b100011;
	localparam funct_t FUNCT_AND = 6'b100100;
	localparam funct_t FUNCT_OR = 6'b100101;
	localparam funct_t FUNCT_XOR = 6'b100110;
	localparam funct_t FUNCT_NOR = 6'b100111;
	localparam funct_t FUNCT_SLT = 6'b101010;

	// cop0 moves, selected by rs
	localparam reg_addr_t RS_MF = 5'b00000;
	localparam reg_addr_t RS_MT = 5'b00100;

	localparam reg_addr_t LINK_REG = 5'd31;
	localparam word_t PC_STEP = 32'd4;

endpackage

// File: common/pipe_pkg.sv
package pipe_pkg;

	////////////////////
	// alu control
	////////////////////
	typedef enum logic [7:0] {
		ALUOP_NOP = 8'b00000000,
		ALUOP_SRL = 8'b00000010,
		ALUOP_SRA = 8'b00000011,
		ALUOP_JR = 8'b00001000,
		ALUOP_ADDU = 8'b00100001,
		ALUOP_SUBU = 8'b00100011,
		ALUOP_AND = 8'b00100100,
		ALUOP_OR = 8'b00100101,
		ALUOP_XOR = 8'b00100110,
		ALUOP_NOR = 8'b00100111,
		ALUOP_SLT = 8'b00101010,
		ALUOP_J = 8'b01001111,
		ALUOP_JAL = 8'b01010000,
		ALUOP_BEQ = 8'b01010001,
		ALUOP_BNE = 8'b01010010,
		ALUOP_ADDIU = 8'b01010110,
		ALUOP_MFC0 = 8'b01011101,
		ALUOP_MTC0 = 8'b01100000,
		ALUOP_SLL = 8'b01111100,
		ALUOP_LW = 8'b11100011,
		ALUOP_SW = 8'b11101011
	} aluop_e;

	// result class seen by EX
	typedef enum logic [2:0] {
		ALUSEL_NOP = 3'b000,
		ALUSEL_LOGIC = 3'b001,
		ALUSEL_SHIFT = 3'b010,
		ALUSEL_MOVE = 3'b011,
		ALUSEL_ARITH = 3'b100,
		ALUSEL_JUMP_BRANCH = 3'b110,
		ALUSEL_LOAD_STORE = 3'b111
	} alusel_e;

	////////////////////
	// stage payloads
	////////////////////
	typedef struct packed {
		logic valid;
		isa_pkg::word_t pc;
		isa_pkg::word_t inst;
	} if_id_t;

	// write-back view of a later stage
	typedef struct packed {
		logic wreg;
		isa_pkg::reg_addr_t wd;
		isa_pkg::word_t wdata;
	} fwd_t;

	typedef struct packed {
		logic re1;
		logic re2;
		isa_pkg::reg_addr_t addr1;
		isa_pkg::reg_addr_t addr2;
	} rf_req_t;

	typedef struct packed {
		logic valid;
		aluop_e aluop;
		alusel_e alusel;
		isa_pkg::word_t reg1;
		isa_pkg::word_t reg2;
		isa_pkg::reg_addr_t wd;
		logic wreg;
		isa_pkg::word_t link_addr;
		logic in_delay_slot;
		logic inst_invalid;
		isa_pkg::word_t pc;
	} id_ex_t;

	typedef struct packed {
		logic taken;
		isa_pkg::word_t target;
	} branch_t;

	typedef logic [1:0] drain_cnt_t;
	// extra stall cycles once mtc0 has left EX
	localparam drain_cnt_t MTC0_DRAIN = 2'd2;

endpackage

// File: decode/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
	input  pipe_pkg::if_id_t   if_id_i,
	output pipe_pkg::rf_req_t  rf_req_o,
	output isa_pkg::word_t     imm_o,
	output pipe_pkg::aluop_e   aluop_o,
	output pipe_pkg::alusel_e  alusel_o,
	output isa_pkg::reg_addr_t wd_o,
	output logic               wreg_o,
	output logic               inst_invalid_o
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t inst;
	opcode_t op;
	funct_t funct;
	reg_addr_t rs, rt, rd;
	logic [SA_W-1:0] sa;
	word_t imm_zext, imm_sext, imm_upper;

	assign inst = if_id_i.inst;
	assign op = inst[OP_LSB +: $bits(opcode_t)];
	assign funct = inst[$bits(funct_t)-1:0];
	assign rs = inst[RS_LSB +: $bits(reg_addr_t)];
	assign rt = inst[RT_LSB +: $bits(reg_addr_t)];
	assign rd = inst[RD_LSB +: $bits(reg_addr_t)];
	assign sa = inst[SA_LSB +: SA_W];
	assign imm_zext = {{($bits(word_t)-IMM_W){1'b0}}, inst[IMM_W-1:0]};
	assign imm_sext = {{($bits(word_t)-IMM_W){inst[IMM_W-1]}}, inst[IMM_W-1:0]};
	assign imm_upper = {inst[IMM_W-1:0], {($bits(word_t)-IMM_W){1'b0}}};

	always_comb begin
		aluop_o = ALUOP_NOP;
		rf_req_o.re1 = 1'b0;
		rf_req_o.re2 = 1'b0;
		rf_req_o.addr1 = rs;
		rf_req_o.addr2 = rt;
		wd_o = rd;
		wreg_o = 1'b0;

		////////////////////
		// opcode to operation
		////////////////////
		// an empty slot decodes as nop, as does the all-zero word
		if (if_id_i.valid && inst != '0) begin
			case (op)
				OPCODE_SPECIAL: begin
					case (funct)
						FUNCT_OR: aluop_o = ALUOP_OR;
						FUNCT_AND: aluop_o = ALUOP_AND;
						FUNCT_XOR: aluop_o = ALUOP_XOR;
						FUNCT_NOR: aluop_o = ALUOP_NOR;
						FUNCT_ADDU: aluop_o = ALUOP_ADDU;
						FUNCT_SUBU: aluop_o = ALUOP_SUBU;
						FUNCT_SLT: aluop_o = ALUOP_SLT;
						FUNCT_SLL: aluop_o = ALUOP_SLL;
						FUNCT_SRL: aluop_o = ALUOP_SRL;
						FUNCT_SRA: aluop_o = ALUOP_SRA;
						FUNCT_JR: aluop_o = ALUOP_JR;
						default: aluop_o = ALUOP_NOP;
					endcase
				end
				// lui is an or of r0 with the shifted immediate
				OPCODE_ORI, OPCODE_LUI: aluop_o = ALUOP_OR;
				OPCODE_ANDI: aluop_o = ALUOP_AND;
				OPCODE_XORI: aluop_o = ALUOP_XOR;
				OPCODE_ADDIU: aluop_o = ALUOP_ADDIU;
				OPCODE_SLTI: aluop_o = ALUOP_SLT;
				OPCODE_LW: aluop_o = ALUOP_LW;
				OPCODE_SW: aluop_o = ALUOP_SW;
				OPCODE_BEQ: aluop_o = ALUOP_BEQ;
				OPCODE_BNE: aluop_o = ALUOP_BNE;
				OPCODE_J: aluop_o = ALUOP_J;
				OPCODE_JAL: aluop_o = ALUOP_JAL;
				OPCODE_COP0: begin
					if (inst[COP0_PAD_LSB +: COP0_PAD_W] == '0 && rs == RS_MF) begin
						aluop_o = ALUOP_MFC0;
					end else if (inst[COP0_PAD_LSB +: COP0_PAD_W] == '0 && rs == RS_MT) begin
						aluop_o = ALUOP_MTC0;
					end
				end
				default: aluop_o = ALUOP_NOP;
			endcase
		end

		// immediate by format
		case (op)
			OPCODE_ORI, OPCODE_ANDI, OPCODE_XORI: imm_o = imm_zext;
			OPCODE_LUI: imm_o = imm_upper;
			OPCODE_ADDIU, OPCODE_SLTI, OPCODE_LW, OPCODE_SW: imm_o = imm_sext;
			default: imm_o = '0;
		endcase

		////////////////////
		// ports and destination
		////////////////////
		case (aluop_o)
			ALUOP_OR, ALUOP_AND, ALUOP_XOR, ALUOP_NOR, ALUOP_ADDU, ALUOP_SUBU,
			ALUOP_SLT, ALUOP_ADDIU, ALUOP_LW: begin
				// r-type reads rt and writes rd, i-type writes rt
				rf_req_o.re1 = 1'b1;
				rf_req_o.re2 = (op == OPCODE_SPECIAL);
				wd_o = (op == OPCODE_SPECIAL) ? rd : rt;
				wreg_o = 1'b1;
			end
			ALUOP_SLL, ALUOP_SRL, ALUOP_SRA: begin
				// shift amount reaches reg1 through the immediate
				rf_req_o.re2 = 1'b1;
				imm_o = word_t'(sa);
				wreg_o = 1'b1;
			end
			ALUOP_SW, ALUOP_BEQ, ALUOP_BNE: begin
				rf_req_o.re1 = 1'b1;
				rf_req_o.re2 = 1'b1;
			end
			ALUOP_JR: rf_req_o.re1 = 1'b1;
			ALUOP_JAL: begin
				wd_o = LINK_REG;
				wreg_o = 1'b1;
			end
			ALUOP_MFC0: begin
				// cp0 register number goes on as reg1
				imm_o = word_t'(rd);
				wd_o = rt;
				wreg_o = 1'b1;
			end
			ALUOP_MTC0: begin
				// rt on port 1, cp0 number in reg2
				rf_req_o.re1 = 1'b1;
				rf_req_o.addr1 = rt;
				imm_o = word_t'(rd);
			end
			default: ;
		endcase
	end

	always_comb begin
		case (aluop_o)
			ALUOP_OR, ALUOP_AND, ALUOP_XOR, ALUOP_NOR: alusel_o = ALUSEL_LOGIC;
			ALUOP_SLL, ALUOP_SRL, ALUOP_SRA: alusel_o = ALUSEL_SHIFT;
			ALUOP_ADDU, ALUOP_SUBU, ALUOP_SLT, ALUOP_ADDIU: alusel_o = ALUSEL_ARITH;
			ALUOP_MFC0: alusel_o = ALUSEL_MOVE;
			ALUOP_BEQ, ALUOP_BNE, ALUOP_J, ALUOP_JAL, ALUOP_JR: alusel_o = ALUSEL_JUMP_BRANCH;
			ALUOP_LW, ALUOP_SW: alusel_o = ALUSEL_LOAD_STORE;
			default: alusel_o = ALUSEL_NOP;
		endcase
	end

	// anything left as nop that is not the nop word
	assign inst_invalid_o = if_id_i.valid && (aluop_o == ALUOP_NOP) && (inst != '0);

endmodule

// File: decode/operand_fwd.sv
`timescale 1ns/1ps

module operand_fwd (
	input  logic               re_i,
	input  isa_pkg::reg_addr_t addr_i,
	input  isa_pkg::word_t     rf_data_i,
	input  isa_pkg::word_t     imm_i,
	input  pipe_pkg::fwd_t     ex_fwd_i,
	input  pipe_pkg::fwd_t     mem_fwd_i,
	output isa_pkg::word_t     operand_o
);

	// youngest writer wins, r0 included
	always_comb begin
		if (!re_i) begin
			operand_o = imm_i;
		end else if (ex_fwd_i.wreg && ex_fwd_i.wd == addr_i) begin
			operand_o = ex_fwd_i.wdata;
		end else if (mem_fwd_i.wreg && mem_fwd_i.wd == addr_i) begin
			operand_o = mem_fwd_i.wdata;
		end else begin
			operand_o = rf_data_i;
		end
	end

endmodule

// File: decode/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
	input  isa_pkg::word_t    pc_i,
	input  isa_pkg::word_t    inst_i,
	input  pipe_pkg::aluop_e  aluop_i,
	input  isa_pkg::word_t    reg1_i,
	input  isa_pkg::word_t    reg2_i,
	input  logic              suppress_i,
	output pipe_pkg::branch_t branch_o,
	output isa_pkg::word_t    link_addr_o
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t pc_next;
	word_t br_offset;
	word_t jump_target;

	assign pc_next = pc_i + PC_STEP;
	// word offset scaled to bytes
	assign br_offset = {{($bits(word_t)-IMM_W-2){inst_i[IMM_W-1]}}, inst_i[IMM_W-1:0], 2'b00};
	// index stays inside the 256 MB region of the delay slot
	assign jump_target = {pc_next[$bits(word_t)-1:JIDX_W+2], inst_i[JIDX_W-1:0], 2'b00};

	always_comb begin
		branch_o = '0;
		if (!suppress_i) begin
			case (aluop_i)
				ALUOP_BEQ, ALUOP_BNE: begin
					branch_o.taken = (reg1_i == reg2_i) ^ (aluop_i == ALUOP_BNE);
					branch_o.target = pc_next + br_offset;
				end
				ALUOP_J, ALUOP_JAL: begin
					branch_o.taken = 1'b1;
					branch_o.target = jump_target;
				end
				ALUOP_JR: begin
					branch_o.taken = 1'b1;
					branch_o.target = reg1_i;
				end
				default: ;
			endcase
		end
	end

	// return past the delay slot
	assign link_addr_o = (aluop_i == ALUOP_JAL) ? pc_next + PC_STEP : '0;

endmodule

// File: logic/hazard_fsm.sv
`timescale 1ns/1ps

module hazard_fsm (
	input  logic              clk,
	input  logic              arst_n_i,
	input  pipe_pkg::aluop_e  ex_aluop_i,
	input  pipe_pkg::fwd_t    ex_fwd_i,
	input  pipe_pkg::rf_req_t rf_req_i,
	output logic              stall_o
);
	import pipe_pkg::*;

	typedef enum logic {
		ST_RUN,
		ST_DRAIN
	} state_e;

	state_e state_q, state_d;
	drain_cnt_t cnt_q, cnt_d;
	logic ex_mtc0;
	logic load_use;

	assign ex_mtc0 = (ex_aluop_i == ALUOP_MTC0);
	// load data is not ready until MEM
	assign load_use = (ex_aluop_i == ALUOP_LW) &&
		((rf_req_i.re1 && rf_req_i.addr1 == ex_fwd_i.wd) ||
		(rf_req_i.re2 && rf_req_i.addr2 == ex_fwd_i.wd));

	always_comb begin
		state_d = state_q;
		cnt_d = cnt_q;
		if (ex_mtc0) begin
			state_d = ST_DRAIN;
			cnt_d = MTC0_DRAIN;
		end else if (state_q == ST_DRAIN) begin
			cnt_d = cnt_q - 1'b1;
			if (cnt_d == '0) begin
				state_d = ST_RUN;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_RUN;
			cnt_q <= '0;
		end else begin
			state_q <= state_d;
			cnt_q <= cnt_d;
		end
	end

	assign stall_o = load_use || ex_mtc0 || (state_q == ST_DRAIN);

	////////////////////
	// checks
	////////////////////
	a_drain_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
		ex_mtc0 ##1 (!ex_mtc0 [*MTC0_DRAIN]) ##1 (!ex_mtc0 && !load_use) |-> !stall_o)
		else $error("stall held past the mtc0 drain window");

	a_run_count: assert property (@(posedge clk) disable iff (!arst_n_i)
		(state_q == ST_RUN) |-> (cnt_q == '0))
		else $error("drain count left over in RUN");

endmodule

// File: logic/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              stall_i,
	input  logic              valid_i,
	input  pipe_pkg::id_ex_t  ctrl_i,
	input  pipe_pkg::branch_t branch_i,
	output logic              in_delay_slot_o,
	output pipe_pkg::id_ex_t  id_ex_o
);
	import pipe_pkg::*;

	logic load;
	logic valid_q, wreg_q, slot_q, invalid_q;
	aluop_e aluop_q;
	alusel_e alusel_q;
	id_ex_t data_q;
	logic delay_q;

	assign load = valid_i && !stall_i;

	// control side, a bubble unless an instruction moves
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= 1'b0;
			wreg_q <= 1'b0;
			slot_q <= 1'b0;
			invalid_q <= 1'b0;
			aluop_q <= ALUOP_NOP;
			alusel_q <= ALUSEL_NOP;
			delay_q <= 1'b0;
		end else if (load) begin
			valid_q <= 1'b1;
			wreg_q <= ctrl_i.wreg;
			slot_q <= ctrl_i.in_delay_slot;
			invalid_q <= ctrl_i.inst_invalid;
			aluop_q <= ctrl_i.aluop;
			alusel_q <= ctrl_i.alusel;
			// next accepted instruction sits in the delay slot
			delay_q <= branch_i.taken;
		end else begin
			valid_q <= 1'b0;
			wreg_q <= 1'b0;
			slot_q <= 1'b0;
			invalid_q <= 1'b0;
			aluop_q <= ALUOP_NOP;
			alusel_q <= ALUSEL_NOP;
		end
	end

	// operands, addresses, pc
	always_ff @(posedge clk) begin
		if (load) begin
			data_q <= ctrl_i;
		end
	end

	always_comb begin
		id_ex_o = data_q;
		id_ex_o.valid = valid_q;
		id_ex_o.wreg = wreg_q;
		id_ex_o.in_delay_slot = slot_q;
		id_ex_o.inst_invalid = invalid_q;
		id_ex_o.aluop = aluop_q;
		id_ex_o.alusel = alusel_q;
	end

	assign in_delay_slot_o = delay_q;

	a_bubble_no_write: assert property (@(posedge clk) disable iff (!arst_n_i)
		!id_ex_o.valid |-> !id_ex_o.wreg)
		else $error("bubble in ID/EX carries a register write");

endmodule

// File: logic/id_stage.sv
`timescale 1ns/1ps

module id_stage (
	input  logic              clk,
	input  logic              arst_n_i,
	input  pipe_pkg::if_id_t  if_id_i,
	input  isa_pkg::word_t    rf_data1_i,
	input  isa_pkg::word_t    rf_data2_i,
	input  pipe_pkg::fwd_t    ex_fwd_i,
	input  pipe_pkg::fwd_t    mem_fwd_i,
	input  pipe_pkg::aluop_e  ex_aluop_i,
	output pipe_pkg::rf_req_t rf_req_o,
	output pipe_pkg::id_ex_t  id_ex_o,
	output pipe_pkg::branch_t branch_o,
	output logic              stall_o
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t dec_imm;
	aluop_e dec_aluop;
	alusel_e dec_alusel;
	reg_addr_t dec_wd;
	logic dec_wreg, dec_invalid;
	word_t reg1, reg2, link_addr;
	logic in_delay_slot;
	id_ex_t ctrl;

	inst_decoder i_decoder (
		.if_id_i(if_id_i), .rf_req_o(rf_req_o), .imm_o(dec_imm),
		.aluop_o(dec_aluop), .alusel_o(dec_alusel), .wd_o(dec_wd),
		.wreg_o(dec_wreg), .inst_invalid_o(dec_invalid)
	);

	operand_fwd i_fwd1 (
		.re_i(rf_req_o.re1), .addr_i(rf_req_o.addr1), .rf_data_i(rf_data1_i),
		.imm_i(dec_imm), .ex_fwd_i(ex_fwd_i), .mem_fwd_i(mem_fwd_i), .operand_o(reg1)
	);

	operand_fwd i_fwd2 (
		.re_i(rf_req_o.re2), .addr_i(rf_req_o.addr2), .rf_data_i(rf_data2_i),
		.imm_i(dec_imm), .ex_fwd_i(ex_fwd_i), .mem_fwd_i(mem_fwd_i), .operand_o(reg2)
	);

	// no redirect while the held instruction waits
	branch_unit i_branch (
		.pc_i(if_id_i.pc), .inst_i(if_id_i.inst), .aluop_i(dec_aluop),
		.reg1_i(reg1), .reg2_i(reg2), .suppress_i(stall_o),
		.branch_o(branch_o), .link_addr_o(link_addr)
	);

	hazard_fsm i_hazard (
		.clk(clk), .arst_n_i(arst_n_i), .ex_aluop_i(ex_aluop_i),
		.ex_fwd_i(ex_fwd_i), .rf_req_i(rf_req_o), .stall_o(stall_o)
	);

	assign ctrl = '{
		valid: if_id_i.valid,
		aluop: dec_aluop,
		alusel: dec_alusel,
		reg1: reg1,
		reg2: reg2,
		wd: dec_wd,
		wreg: dec_wreg,
		link_addr: link_addr,
		in_delay_slot: in_delay_slot,
		inst_invalid: dec_invalid,
		pc: if_id_i.pc
	};

	id_ex_reg i_id_ex (
		.clk(clk), .arst_n_i(arst_n_i), .stall_i(stall_o), .valid_i(if_id_i.valid),
		.ctrl_i(ctrl), .branch_i(branch_o), .in_delay_slot_o(in_delay_slot),
		.id_ex_o(id_ex_o)
	);

endmodule

// File: bench/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
	import isa_pkg::*;
	import pipe_pkg::*;

	typedef struct {
		if_id_t fetch;
		word_t rf1;
		word_t rf2;
		fwd_t exf;
		fwd_t memf;
		aluop_e exop;
		rf_req_t req;
		id_ex_t exp;
		branch_t br;
		logic stall;
	} row_t;

	logic clk;
	logic arst_n_i;
	if_id_t if_id;
	word_t rf_data1;
	word_t rf_data2;
	fwd_t ex_fwd;
	fwd_t mem_fwd;
	aluop_e ex_aluop;
	rf_req_t rf_req;
	id_ex_t id_ex;
	branch_t branch;
	logic stall;

	row_t rows[$];
	row_t cur;
	word_t pc_next;
	int row_idx;

	id_stage i_dut (
		.clk(clk), .arst_n_i(arst_n_i), .if_id_i(if_id), .rf_data1_i(rf_data1),
		.rf_data2_i(rf_data2), .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd),
		.ex_aluop_i(ex_aluop), .rf_req_o(rf_req), .id_ex_o(id_ex),
		.branch_o(branch), .stall_o(stall)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// watchdog for the whole run
	initial begin
		repeat (2000) @(posedge clk);
		$display("simulation ran past its cycle limit");
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

	////////////////////
	// checks
	////////////////////
	task automatic stop_run(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic mismatch(input string name, input string got, input string exp);
		$display("FAILED %s at row %0d: got %s expected %s", name, row_idx, got, exp);
		stop_run("value mismatch");
	endtask

	task automatic check_stall(input logic got, input logic exp);
		if (got !== exp) mismatch("stall_o", $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	// target only matters when taken
	task automatic check_branch(input branch_t got, input branch_t exp);
		if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target)) begin
			mismatch("branch_o", $sformatf("%h", got), $sformatf("%h", exp));
		end
	endtask

	// an address only matters when its port is enabled
	task automatic check_rf_req(input rf_req_t got, input rf_req_t exp);
		if (got.re1 !== exp.re1 || got.re2 !== exp.re2 ||
			(exp.re1 && got.addr1 !== exp.addr1) ||
			(exp.re2 && got.addr2 !== exp.addr2)) begin
			mismatch("rf_req_o", $sformatf("%h", got), $sformatf("%h", exp));
		end
	endtask

	task automatic check_id_ex(input id_ex_t got, input id_ex_t exp);
		if (!exp.valid) begin
			if (got.valid !== 1'b0 || got.wreg !== 1'b0) begin
				mismatch("id_ex_o.valid/wreg", $sformatf("%h", {got.valid, got.wreg}), "0");
			end
		end else if (got !== exp) begin
			mismatch("id_ex_o", $sformatf("%h", got), $sformatf("%h", exp));
		end
	endtask

	////////////////////
	// table
	////////////////////
	function automatic word_t enc_i(opcode_t op, reg_addr_t rs, reg_addr_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t enc_r(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
		logic [4:0] sa, funct_t funct);
		return {OPCODE_SPECIAL, rs, rt, rd, sa, funct};
	endfunction

	task automatic new_row(input word_t inst);
		cur.fetch = '{valid: 1'b1, pc: pc_next, inst: inst};
		pc_next = pc_next + PC_STEP;
		cur.rf1 = $urandom();
		cur.rf2 = $urandom();
		cur.exf = '0;
		cur.memf = '0;
		cur.exop = ALUOP_NOP;
		cur.req = '0;
		cur.exp = '0;
		cur.br = '0;
		cur.stall = 1'b0;
	endtask

	task automatic expect_req(input logic en1, input logic en2, input reg_addr_t a1,
		input reg_addr_t a2);
		cur.req = '{re1: en1, re2: en2, addr1: a1, addr2: a2};
	endtask

	task automatic expect_op(input aluop_e op, input alusel_e sel, input word_t r1,
		input word_t r2, input reg_addr_t wd, input logic wreg, input logic slot);
		cur.exp = '{valid: 1'b1, aluop: op, alusel: sel, reg1: r1, reg2: r2, wd: wd,
			wreg: wreg, link_addr: '0, in_delay_slot: slot, inst_invalid: 1'b0,
			pc: cur.fetch.pc};
	endtask

	task automatic build_table();
		// immediates
		new_row(enc_i(OPCODE_ORI, 5'd1, 5'd2, 16'h8001));
		expect_req(1'b1, 1'b0, 5'd1, 5'd0);
		expect_op(ALUOP_OR, ALUSEL_LOGIC, cur.rf1, 32'h0000_8001, 5'd2, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(enc_i(OPCODE_ANDI, 5'd3, 5'd4, 16'hF0F0));
		expect_req(1'b1, 1'b0, 5'd3, 5'd0);
		expect_op(ALUOP_AND, ALUSEL_LOGIC, cur.rf1, 32'h0000_F0F0, 5'd4, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(enc_i(OPCODE_XORI, 5'd5, 5'd6, 16'hFFFF));
		expect_req(1'b1, 1'b0, 5'd5, 5'd0);
		expect_op(ALUOP_XOR, ALUSEL_LOGIC, cur.rf1, 32'h0000_FFFF, 5'd6, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(enc_i(OPCODE_ADDIU, 5'd7, 5'd8, 16'hFFFC));
		expect_req(1'b1, 1'b0, 5'd7, 5'd0);
		expect_op(ALUOP_ADDIU, ALUSEL_ARITH, cur.rf1, 32'hFFFF_FFFC, 5'd8, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(enc_i(OPCODE_SLTI, 5'd9, 5'd10, 16'h8000));
		expect_req(1'b1, 1'b0, 5'd9, 5'd0);
		expect_op(ALUOP_SLT, ALUSEL_ARITH, cur.rf1, 32'hFFFF_8000, 5'd10, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(enc_i(OPCODE_LUI, 5'd0, 5'd11, 16'h1234));
		expect_req(1'b1, 1'b0, 5'd0, 5'd0);
		expect_op(ALUOP_OR, ALUSEL_LOGIC, cur.rf1, 32'h1234_0000, 5'd11, 1'b1, 1'b0);
		rows.push_back(cur);
		// r-type and shifts
		new_row(enc_r(5'd1, 5'd2, 5'd3, 5'd0, FUNCT_ADDU));
		expect_req(1'b1, 1'b1, 5'd1, 5'd2);
		expect_op(ALUOP_ADDU, ALUSEL_ARITH, cur.rf1, cur.rf2, 5'd3, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(enc_r(5'd4, 5'd5, 5'd6, 5'd0, FUNCT_NOR));
		expect_req(1'b1, 1'b1, 5'd4, 5'd5);
		expect_op(ALUOP_NOR, ALUSEL_LOGIC, cur.rf1, cur.rf2, 5'd6, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(enc_r(5'd7, 5'd8, 5'd9, 5'd0, FUNCT_SUBU));
		expect_req(1'b1, 1'b1, 5'd7, 5'd8);
		expect_op(ALUOP_SUBU, ALUSEL_ARITH, cur.rf1, cur.rf2, 5'd9, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(enc_r(5'd0, 5'd7, 5'd8, 5'd5, FUNCT_SLL));
		expect_req(1'b0, 1'b1, 5'd0, 5'd7);
		expect_op(ALUOP_SLL, ALUSEL_SHIFT, 32'd5, cur.rf2, 5'd8, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(enc_r(5'd0, 5'd11, 5'd12, 5'd3, FUNCT_SRL));
		expect_req(1'b0, 1'b1, 5'd0, 5'd11);
		expect_op(ALUOP_SRL, ALUSEL_SHIFT, 32'd3, cur.rf2, 5'd12, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(enc_r(5'd0, 5'd9, 5'd10, 5'd31, FUNCT_SRA));
		expect_req(1'b0, 1'b1, 5'd0, 5'd9);
		expect_op(ALUOP_SRA, ALUSEL_SHIFT, 32'd31, cur.rf2, 5'd10, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(32'hFC00_0000);
		expect_op(ALUOP_NOP, ALUSEL_NOP, '0, '0, 5'd0, 1'b0, 1'b0);
		cur.exp.inst_invalid = 1'b1;
		rows.push_back(cur);
		new_row('0);
		expect_op(ALUOP_NOP, ALUSEL_NOP, '0, '0, 5'd0, 1'b0, 1'b0);
		rows.push_back(cur);
		// forwarding priority
		new_row(enc_r(5'd1, 5'd2, 5'd3, 5'd0, FUNCT_ADDU));
		expect_req(1'b1, 1'b1, 5'd1, 5'd2);
		cur.exop = ALUOP_ADDU;
		cur.exf = '{wreg: 1'b1, wd: 5'd1, wdata: $urandom()};
		cur.memf = '{wreg: 1'b1, wd: 5'd2, wdata: $urandom()};
		expect_op(ALUOP_ADDU, ALUSEL_ARITH, cur.exf.wdata, cur.memf.wdata, 5'd3, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(enc_r(5'd1, 5'd2, 5'd3, 5'd0, FUNCT_ADDU));
		expect_req(1'b1, 1'b1, 5'd1, 5'd2);
		cur.exop = ALUOP_ADDU;
		cur.exf = '{wreg: 1'b1, wd: 5'd1, wdata: $urandom()};
		cur.memf = '{wreg: 1'b1, wd: 5'd1, wdata: $urandom()};
		expect_op(ALUOP_ADDU, ALUSEL_ARITH, cur.exf.wdata, cur.rf2, 5'd3, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row(enc_r(5'd1, 5'd2, 5'd3, 5'd0, FUNCT_ADDU));
		expect_req(1'b1, 1'b1, 5'd1, 5'd2);
		cur.exf = '{wreg: 1'b0, wd: 5'd1, wdata: $urandom()};
		cur.memf = '{wreg: 1'b1, wd: 5'd9, wdata: $urandom()};
		expect_op(ALUOP_ADDU, ALUSEL_ARITH, cur.rf1, cur.rf2, 5'd3, 1'b1, 1'b0);
		rows.push_back(cur);
		////////////////////
		// branches and jumps
		////////////////////
		new_row(enc_i(OPCODE_BEQ, 5'd1, 5'd2, 16'h0010));
		expect_req(1'b1, 1'b1, 5'd1, 5'd2);
		cur.rf2 = cur.rf1;
		expect_op(ALUOP_BEQ, ALUSEL_JUMP_BRANCH, cur.rf1, cur.rf2, 5'd0, 1'b0, 1'b0);
		cur.br = '{taken: 1'b1, target: cur.fetch.pc + PC_STEP + 32'h40};
		rows.push_back(cur);
		new_row(enc_i(OPCODE_ORI, 5'd1, 5'd2, 16'h0001));
		expect_req(1'b1, 1'b0, 5'd1, 5'd0);
		expect_op(ALUOP_OR, ALUSEL_LOGIC, cur.rf1, 32'd1, 5'd2, 1'b1, 1'b1);
		rows.push_back(cur);
		new_row(enc_i(OPCODE_BNE, 5'd1, 5'd2, 16'hFFF0));
		expect_req(1'b1, 1'b1, 5'd1, 5'd2);
		cur.rf2 = ~cur.rf1;
		expect_op(ALUOP_BNE, ALUSEL_JUMP_BRANCH, cur.rf1, cur.rf2, 5'd31, 1'b0, 1'b0);
		cur.br = '{taken: 1'b1, target: cur.fetch.pc + PC_STEP - 32'h40};
		rows.push_back(cur);
		new_row(enc_i(OPCODE_BEQ, 5'd3, 5'd4, 16'h0008));
		expect_req(1'b1, 1'b1, 5'd3, 5'd4);
		cur.rf2 = ~cur.rf1;
		expect_op(ALUOP_BEQ, ALUSEL_JUMP_BRANCH, cur.rf1, cur.rf2, 5'd0, 1'b0, 1'b1);
		rows.push_back(cur);
		new_row({OPCODE_J, 26'h012_3456});
		expect_op(ALUOP_J, ALUSEL_JUMP_BRANCH, '0, '0, cur.fetch.inst[15:11], 1'b0, 1'b0);
		cur.br = '{taken: 1'b1, target: {cur.fetch.pc[31:28], 26'h012_3456, 2'b00}};
		rows.push_back(cur);
		new_row({OPCODE_JAL, 26'h000_0040});
		expect_op(ALUOP_JAL, ALUSEL_JUMP_BRANCH, '0, '0, LINK_REG, 1'b1, 1'b1);
		cur.exp.link_addr = cur.fetch.pc + 2 * PC_STEP;
		cur.br = '{taken: 1'b1, target: {cur.fetch.pc[31:28], 26'h000_0040, 2'b00}};
		rows.push_back(cur);
		new_row(enc_r(5'd4, 5'd0, 5'd0, 5'd0, FUNCT_JR));
		expect_req(1'b1, 1'b0, 5'd4, 5'd0);
		expect_op(ALUOP_JR, ALUSEL_JUMP_BRANCH, cur.rf1, '0, 5'd0, 1'b0, 1'b1);
		cur.br = '{taken: 1'b1, target: cur.rf1};
		rows.push_back(cur);
		new_row(enc_i(OPCODE_ORI, 5'd1, 5'd2, 16'h0002));
		expect_req(1'b1, 1'b0, 5'd1, 5'd0);
		expect_op(ALUOP_OR, ALUSEL_LOGIC, cur.rf1, 32'd2, 5'd2, 1'b1, 1'b1);
		rows.push_back(cur);
		// load-use: branch held and suppressed, then taken once
		new_row(enc_i(OPCODE_BEQ, 5'd5, 5'd6, 16'h0004));
		expect_req(1'b1, 1'b1, 5'd5, 5'd6);
		cur.exop = ALUOP_LW;
		cur.exf = '{wreg: 1'b1, wd: 5'd5, wdata: $urandom()};
		cur.stall = 1'b1;
		rows.push_back(cur);
		cur.exop = ALUOP_ADDU;
		cur.exf = '0;
		cur.memf = '{wreg: 1'b1, wd: 5'd5, wdata: cur.rf2};
		cur.stall = 1'b0;
		expect_op(ALUOP_BEQ, ALUSEL_JUMP_BRANCH, cur.rf2, cur.rf2, 5'd0, 1'b0, 1'b0);
		cur.br = '{taken: 1'b1, target: cur.fetch.pc + PC_STEP + 32'h10};
		rows.push_back(cur);
		new_row(enc_i(OPCODE_ORI, 5'd1, 5'd2, 16'h0003));
		expect_req(1'b1, 1'b0, 5'd1, 5'd0);
		expect_op(ALUOP_OR, ALUSEL_LOGIC, cur.rf1, 32'd3, 5'd2, 1'b1, 1'b1);
		rows.push_back(cur);
		// mtc0 in EX, three stalled cycles
		new_row(enc_i(OPCODE_ORI, 5'd1, 5'd2, 16'h0055));
		expect_req(1'b1, 1'b0, 5'd1, 5'd0);
		cur.exop = ALUOP_MTC0;
		cur.stall = 1'b1;
		rows.push_back(cur);
		cur.exop = ALUOP_NOP;
		rows.push_back(cur);
		rows.push_back(cur);
		cur.stall = 1'b0;
		expect_op(ALUOP_OR, ALUSEL_LOGIC, cur.rf1, 32'h55, 5'd2, 1'b1, 1'b0);
		rows.push_back(cur);
		// cop0 moves
		new_row({OPCODE_COP0, RS_MT, 5'd3, 5'd12, 11'd0});
		expect_req(1'b1, 1'b0, 5'd3, 5'd0);
		expect_op(ALUOP_MTC0, ALUSEL_NOP, cur.rf1, 32'd12, 5'd12, 1'b0, 1'b0);
		rows.push_back(cur);
		new_row({OPCODE_COP0, RS_MF, 5'd7, 5'd12, 11'd0});
		expect_op(ALUOP_MFC0, ALUSEL_MOVE, 32'd12, 32'd12, 5'd7, 1'b1, 1'b0);
		rows.push_back(cur);
		new_row('0);
		cur.fetch.valid = 1'b0;
		rows.push_back(cur);
	endtask

	task automatic apply_row(input row_t r);
		if_id <= r.fetch;
		rf_data1 <= r.rf1;
		rf_data2 <= r.rf2;
		ex_fwd <= r.exf;
		mem_fwd <= r.memf;
		ex_aluop <= r.exop;
	endtask

	// counts stalled cycles from an mtc0 in EX
	task automatic measure_drain(output int cycles);
		cycles = 0;
		@(posedge clk);
		ex_aluop <= ALUOP_MTC0;
		@(negedge clk);
		while (stall) begin
			cycles++;
			if (cycles > 8) stop_run("stall did not clear after mtc0");
			@(posedge clk);
			ex_aluop <= ALUOP_NOP;
			@(negedge clk);
		end
	endtask

	initial begin
		int drain;

		void'($urandom(73017));
		arst_n_i = 1'b0;
		if_id = '0;
		rf_data1 = '0;
		rf_data2 = '0;
		ex_fwd = '0;
		mem_fwd = '0;
		ex_aluop = ALUOP_NOP;
		pc_next = 32'hB000_1000;
		row_idx = -1;
		repeat (5) @(posedge clk);
		arst_n_i <= 1'b1;
		@(negedge clk);
		check_id_ex(id_ex, '0);
		check_stall(stall, 1'b0);
		check_branch(branch, '0);
		check_rf_req(rf_req, '0);

		build_table();
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			apply_row(rows[i]);
			@(negedge clk);
			row_idx = i;
			check_stall(stall, rows[i].stall);
			check_branch(branch, rows[i].br);
			check_rf_req(rf_req, rows[i].req);
			if (i > 0) check_id_ex(id_ex, rows[i-1].exp);
		end
		@(posedge clk);
		@(negedge clk);
		check_id_ex(id_ex, rows[rows.size()-1].exp);

		measure_drain(drain);
		if (drain != 3) mismatch("stall_o cycles", $sformatf("%h", drain), "3");

		$display("all tests passed");
		$finish;
	end

endmodule

// File: compile.f
common/isa_pkg.sv
common/pipe_pkg.sv
decode/inst_decoder.sv
decode/operand_fwd.sv
decode/branch_unit.sv
logic/hazard_fsm.sv
logic/id_ex_reg.sv
logic/id_stage.sv
bench/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_id_stage
RTL_TOP ?= id_stage
FLIST ?= compile.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
